// File: all.f
verilog/dbg_trig_pkg.sv
verilog/trigger_warl.sv
verilog/trigger_csrs.sv
verilog/trigger_match.sv
verilog/dbg_triggers.sv
testbench/dbg_triggers_chk.sv
testbench/tb_dbg_triggers.sv

// File: testbench/tb_dbg_triggers.sv
`timescale 1ns/1ps

module tb_dbg_triggers;
  import dbg_trig_pkg::*;

  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 60;                  // Longest test is well below this
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST + 200;
  localparam logic [2:0] WE_TSEL = 3'b100;              // Strobe order as in csr_wr_t
  localparam logic [2:0] WE_T1   = 3'b010;
  localparam logic [2:0] WE_T2   = 3'b001;
  localparam logic [XLEN-1:0] MC6_FIXED = 32'h0800_1000;  // dmode set, action 1

  logic            clk;
  logic            reset_i;
  csr_wr_t         csr_wr;
  csr_rd_t         csr_rd;
  logic [XLEN-1:0] pc_if;
  priv_lvl_e       priv_if;
  lsu_req_t        lsu_ex;
  exc_wb_t         exc_wb;
  logic            debug_mode;
  logic            match_if;
  logic            match_ex;
  logic            etrigger_wb;
  int              errors;
  int              checks;
  int              tests_run;
  logic [XLEN-1:0] base;                                // Random trigger address

  dbg_triggers uut (
    .clk          (clk),
    .reset_i      (reset_i),
    .csr_wr_i     (csr_wr),
    .csr_rd_o     (csr_rd),
    .pc_if_i      (pc_if),
    .priv_if_i    (priv_if),
    .lsu_ex_i     (lsu_ex),
    .exc_wb_i     (exc_wb),
    .debug_mode_i (debug_mode),
    .match_if_o   (match_if),
    .match_ex_o   (match_ex),
    .etrigger_wb_o(etrigger_wb)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                             // 100 ns period
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Raw mcontrol6 write data, u left clear
  function automatic logic [XLEN-1:0] mc6_cfg(input logic [3:0] match, input logic m,
                                             input logic exe, input logic st, input logic ld);
    logic [XLEN-1:0] w;
    w                            = '0;
    w[TTYPE_HI:TTYPE_LO]         = TT_MCONTROL6;
    w[MC6_MATCH_HI:MC6_MATCH_LO] = match;
    w[MC6_M]                     = m;
    w[MC6_EXECUTE]               = exe;
    w[MC6_STORE]                 = st;
    w[MC6_LOAD]                  = ld;
    return w;
  endfunction

  // One-cycle strobe, register updates on the following edge
  task automatic write_csr(input logic [2:0] we, input logic [XLEN-1:0] data);
    @(posedge clk);
    csr_wr <= {data, we};
    @(posedge clk);
    csr_wr <= '0;
    @(negedge clk);                                     // Read back mid-cycle
  endtask

  task automatic fetch_case(input logic [XLEN-1:0] pc, input priv_lvl_e priv, input logic exp);
    @(posedge clk);
    pc_if   <= pc;
    priv_if <= priv;
    @(negedge clk);
    check_value("match_if_o", match_if, exp);
  endtask

  task automatic lsu_case(input logic [XLEN-1:0] addr, input logic we, input logic [3:0] be,
                          input logic exp);
    @(posedge clk);
    lsu_ex <= {1'b1, addr, we, be, PRIV_M};
    @(negedge clk);
    check_value("match_ex_o", match_ex, exp);
  endtask

  task automatic exc_case(input logic valid, input logic [10:0] cause, input priv_lvl_e priv,
                          input logic exp);
    @(posedge clk);
    exc_wb <= {valid, cause, priv};
    @(negedge clk);
    check_value("etrigger_wb_o", etrigger_wb, exp);
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) $display("test %-14s ok", name);
    else $display("test %-14s failed with %0d errors", name, errors - errors_before);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset_tselect();
    int e0;
    e0 = errors;
    check_value("tselect", csr_rd.tselect, 32'd0);
    check_value("tdata1", csr_rd.tdata1, 32'hF800_0000);   // Disabled, dmode set
    check_value("tdata2", csr_rd.tdata2, 32'd0);
    check_value("tdata3", csr_rd.tdata3, 32'd0);
    check_value("tinfo", csr_rd.tinfo, 32'h0000_8060);
    check_value("tcontrol", csr_rd.tcontrol, 32'd0);
    check_value("match_if_o", match_if, 1'b0);
    check_value("match_ex_o", match_ex, 1'b0);
    check_value("etrigger_wb_o", etrigger_wb, 1'b0);
    write_csr(WE_TSEL, 32'd1);
    check_value("tselect", csr_rd.tselect, 32'd1);
    check_value("tdata1", csr_rd.tdata1, 32'hF800_0000);   // Trigger 1 also at reset value
    write_csr(WE_TSEL, 32'd5);                              // Out of range, ignored
    check_value("tselect", csr_rd.tselect, 32'd1);
    end_test("reset_tselect", e0);
  endtask

  task automatic test_tdata1_warl();
    int e0;
    e0 = errors;
    write_csr(WE_T1, 32'h6000_00C4);                        // mcontrol6, match 1, m, execute
    check_value("tdata1", csr_rd.tdata1, 32'h6800_1044);    // match falls back to 0
    write_csr(WE_T1, 32'h2000_0044);                        // Legacy mcontrol
    check_value("tdata1", csr_rd.tdata1, 32'hF800_0000);
    write_csr(WE_T2, 32'h0000_0010);
    check_value("tdata2", csr_rd.tdata2, 32'h0000_0010);
    write_csr(WE_T1, 32'h5000_0200);                        // Cause 4 unsupported, rejected
    check_value("tdata1", csr_rd.tdata1, 32'hF800_0000);
    write_csr(WE_T2, 32'h0000_0800);
    write_csr(WE_T1, 32'h5000_0200);
    check_value("tdata1", csr_rd.tdata1, 32'h5800_0201);
    write_csr(WE_T2, 32'hFFFF_FFFF);
    check_value("tdata2", csr_rd.tdata2, 32'h0000_09AF);    // Only implemented causes kept
    end_test("tdata1_warl", e0);
  endtask

  task automatic test_fetch_match();
    int e0;
    e0 = errors;
    base = ($urandom & 32'h7FFF_FFFC) | 32'h0000_1000;      // Room for +/-4
    write_csr(WE_TSEL, 32'd0);
    write_csr(WE_T2, base);
    write_csr(WE_T1, mc6_cfg(MATCH_EQ, 1'b1, 1'b1, 1'b0, 1'b0));
    check_value("tdata1", csr_rd.tdata1, mc6_cfg(MATCH_EQ, 1'b1, 1'b1, 1'b0, 1'b0) | MC6_FIXED);
    fetch_case(base, PRIV_M, 1'b1);
    fetch_case(base, PRIV_U, 1'b0);                         // u not enabled
    fetch_case(base + 4, PRIV_M, 1'b0);
    write_csr(WE_T1, mc6_cfg(MATCH_GE, 1'b1, 1'b1, 1'b0, 1'b0));
    fetch_case(base - 4, PRIV_M, 1'b0);
    fetch_case(base, PRIV_M, 1'b1);
    fetch_case(base + 4, PRIV_M, 1'b1);
    write_csr(WE_T1, mc6_cfg(MATCH_LT, 1'b1, 1'b1, 1'b0, 1'b0));
    fetch_case(base - 4, PRIV_M, 1'b1);
    fetch_case(base, PRIV_M, 1'b0);
    fetch_case(base + 4, PRIV_M, 1'b0);
    @(posedge clk);
    debug_mode <= 1'b1;
    fetch_case(base - 4, PRIV_M, 1'b0);                     // Would hit outside debug mode
    @(posedge clk);
    debug_mode <= 1'b0;
    end_test("fetch_match", e0);
  endtask

  task automatic test_lsu_match();
    int              e0;
    logic [XLEN-1:0] word;
    e0   = errors;
    base = ($urandom & 32'hFFFF_FFFC) | 32'h2;              // Byte 2 of a word
    word = base & 32'hFFFF_FFFC;
    write_csr(WE_T2, base);
    write_csr(WE_T1, mc6_cfg(MATCH_EQ, 1'b1, 1'b0, 1'b1, 1'b1));
    lsu_case(word, 1'b0, 4'b0100, 1'b1);
    lsu_case(word, 1'b0, 4'b1100, 1'b1);
    lsu_case(word, 1'b0, 4'b0011, 1'b0);                    // Byte 2 not accessed
    write_csr(WE_T1, mc6_cfg(MATCH_EQ, 1'b1, 1'b0, 1'b1, 1'b0));
    lsu_case(word, 1'b0, 4'b0100, 1'b0);                    // Store only, load ignored
    lsu_case(word, 1'b1, 4'b0100, 1'b1);
    write_csr(WE_T1, mc6_cfg(MATCH_GE, 1'b1, 1'b0, 1'b0, 1'b1));
    lsu_case(word, 1'b0, 4'b0011, 1'b0);                    // Highest byte is 1
    lsu_case(word, 1'b0, 4'b1000, 1'b1);
    lsu_case(word, 1'b0, 4'b1001, 1'b1);
    write_csr(WE_T1, mc6_cfg(MATCH_LT, 1'b1, 1'b0, 1'b0, 1'b1));
    lsu_case(word, 1'b0, 4'b1100, 1'b0);                    // Lowest byte is 2
    lsu_case(word, 1'b0, 4'b0110, 1'b1);
    lsu_case(word, 1'b0, 4'b1001, 1'b1);
    @(posedge clk);
    lsu_ex <= '0;
    end_test("lsu_match", e0);
  endtask

  task automatic test_exc_trigger();
    int e0;
    e0 = errors;
    write_csr(WE_TSEL, 32'd1);
    write_csr(WE_T2, 32'h0000_0800);                        // Cause 11 only
    write_csr(WE_T1, 32'h5000_0200);                        // Exception trigger, m set
    check_value("tdata2", csr_rd.tdata2, 32'h0000_0800);
    check_value("tdata1", csr_rd.tdata1, 32'h5800_0201);
    exc_case(1'b1, 11'd11, PRIV_M, 1'b1);
    exc_case(1'b1, 11'd2, PRIV_M, 1'b0);
    exc_case(1'b1, 11'd11, PRIV_U, 1'b0);
    exc_case(1'b0, 11'd11, PRIV_M, 1'b0);
    end_test("exc_trigger", e0);
  endtask

  initial begin
    void'($urandom(32'h7fb5_b838));
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    reset_i    <= 1'b1;
    csr_wr     <= '0;
    pc_if      <= '0;
    priv_if    <= PRIV_M;
    lsu_ex     <= '0;
    exc_wb     <= '0;
    debug_mode <= 1'b0;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    test_reset_tselect();
    test_tdata1_warl();
    test_fetch_match();
    test_lsu_match();
    test_exc_trigger();
    $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: testbench/dbg_triggers_chk.sv
`timescale 1ns/1ps

module dbg_triggers_chk (
  input logic                  clk,
  input logic                  reset_i,
  input logic                  debug_mode_i,
  input logic                  match_if_i,
  input logic                  match_ex_i,
  input logic                  etrigger_wb_i,
  input dbg_trig_pkg::exc_wb_t exc_wb_i,   // WB exception as seen by the DUT
  input dbg_trig_pkg::csr_rd_t csr_rd_i
);
  import dbg_trig_pkg::*;

  // Debug mode masks every trigger
  a_quiet_in_debug: assert property (@(posedge clk) disable iff (reset_i)
    debug_mode_i |-> !(match_if_i || match_ex_i || etrigger_wb_i))
    else $error("match output high while in debug mode");

  a_etrig_needs_exc: assert property (@(posedge clk) disable iff (reset_i)
    etrigger_wb_i |-> exc_wb_i.valid)   // No exception, no hit
    else $error("exception trigger fired without a valid exception");

  a_tselect_range: assert property (@(posedge clk) disable iff (reset_i)
    csr_rd_i.tselect < XLEN'(NUM_TRIGGERS))
    else $error("tselect outside the implemented triggers");

endmodule

bind dbg_triggers dbg_triggers_chk u_chk (
  .clk          (clk),
  .reset_i      (reset_i),
  .debug_mode_i (debug_mode_i),
  .match_if_i   (match_if_o),
  .match_ex_i   (match_ex_o),
  .etrigger_wb_i(etrigger_wb_o),
  .exc_wb_i     (exc_wb_i),
  .csr_rd_i     (csr_rd_o)
);

// File: verilog/dbg_triggers.sv
`timescale 1ns/1ps

module dbg_triggers (
  input  logic                            clk,
  input  logic                            reset_i,
  input  dbg_trig_pkg::csr_wr_t           csr_wr_i,      // CSR write strobes and data
  output dbg_trig_pkg::csr_rd_t           csr_rd_o,      // CSR read data
  input  logic [dbg_trig_pkg::XLEN-1:0]   pc_if_i,       // Fetch PC
  input  dbg_trig_pkg::priv_lvl_e         priv_if_i,
  input  dbg_trig_pkg::lsu_req_t          lsu_ex_i,      // EX stage load/store
  input  dbg_trig_pkg::exc_wb_t           exc_wb_i,      // WB stage exception
  input  logic                            debug_mode_i,
  output logic                            match_if_o,    // Instruction address hit
  output logic                            match_ex_o,    // Load/store address hit
  output logic                            etrigger_wb_o  // Exception hit
);
  import dbg_trig_pkg::*;

  logic [XLEN-1:0] tselect_n;                  // WARL resolved next values
  logic [XLEN-1:0] tdata1_n;
  logic [XLEN-1:0] tdata2_n;
  trig_cfg_t       cfg [NUM_TRIGGERS];         // Per-trigger configuration

  logic [NUM_TRIGGERS-1:0] match_if;
  logic [NUM_TRIGGERS-1:0] match_ex;
  logic [NUM_TRIGGERS-1:0] etrig_wb;

  // Resolve write data against the selected trigger's current state
  trigger_warl u_warl (
    .wdata_i      (csr_wr_i.wdata),
    .cur_tselect_i(csr_rd_o.tselect),
    .cur_tdata1_i (csr_rd_o.tdata1),
    .cur_tdata2_i (csr_rd_o.tdata2),
    .tselect_n_o  (tselect_n),
    .tdata1_n_o   (tdata1_n),
    .tdata2_n_o   (tdata2_n)
  );

  trigger_csrs u_csrs (
    .clk        (clk),
    .reset_i    (reset_i),
    .csr_wr_i   (csr_wr_i),
    .tselect_n_i(tselect_n),
    .tdata1_n_i (tdata1_n),
    .tdata2_n_i (tdata2_n),
    .cfg_o      (cfg),
    .csr_rd_o   (csr_rd_o)
  );

  // One matcher per trigger
  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : g_trig
    trigger_match u_match (
      .cfg_i       (cfg[t]),
      .pc_if_i     (pc_if_i),
      .priv_if_i   (priv_if_i),
      .lsu_ex_i    (lsu_ex_i),
      .exc_wb_i    (exc_wb_i),
      .debug_mode_i(debug_mode_i),
      .match_if_o  (match_if[t]),
      .match_ex_o  (match_ex[t]),
      .etrigger_o  (etrig_wb[t])
    );
  end

  assign match_if_o    = |match_if;   // Any trigger fires
  assign match_ex_o    = |match_ex;
  assign etrigger_wb_o = |etrig_wb;

endmodule

// File: verilog/trigger_match.sv
`timescale 1ns/1ps

module trigger_match (
  input  dbg_trig_pkg::trig_cfg_t         cfg_i,         // Stored tdata1 / tdata2
  input  logic [dbg_trig_pkg::XLEN-1:0]   pc_if_i,
  input  dbg_trig_pkg::priv_lvl_e         priv_if_i,
  input  dbg_trig_pkg::lsu_req_t          lsu_ex_i,
  input  dbg_trig_pkg::exc_wb_t           exc_wb_i,
  input  logic                            debug_mode_i,  // Suppresses all matches
  output logic                            match_if_o,
  output logic                            match_ex_o,
  output logic                            etrigger_o
);
  import dbg_trig_pkg::*;

  logic            is_mc6;        // Configured as mcontrol6
  logic            is_etrig;      // Configured as exception trigger
  match_e          match_rule;
  logic [XLEN-1:0] tdata2;
  logic            if_addr_hit;
  logic [1:0]      be_hi_lsb;     // Highest enabled byte index
  logic [1:0]      be_lo_lsb;     // Lowest enabled byte index
  logic [XLEN-1:0] lsu_addr_hi;
  logic [XLEN-1:0] lsu_addr_lo;
  logic [3:0]      byte_sel;      // One-hot byte picked by tdata2[1:0]
  logic            lsu_addr_hit;
  logic            lsu_dir_en;    // Access direction enabled
  logic            exc_code_hit;

  // Privilege filter shared by all three paths
  function automatic logic priv_enabled(input priv_lvl_e lvl, input logic m_en,
                                        input logic u_en);
    return (m_en && (lvl == PRIV_M)) || (u_en && (lvl == PRIV_U));
  endfunction

  assign is_mc6     = cfg_i.tdata1[TTYPE_HI:TTYPE_LO] == TT_MCONTROL6;
  assign is_etrig   = cfg_i.tdata1[TTYPE_HI:TTYPE_LO] == TT_ETRIGGER;
  assign match_rule = match_e'(cfg_i.tdata1[MC6_MATCH_HI:MC6_MATCH_LO]);
  assign tdata2     = cfg_i.tdata2;

  ////////////////////////////////////////
  // Fetch address
  ////////////////////////////////////////

  always_comb begin
    case (match_rule)
      MATCH_EQ: if_addr_hit = pc_if_i == tdata2;
      MATCH_GE: if_addr_hit = pc_if_i >= tdata2;
      default:  if_addr_hit = pc_if_i <  tdata2;   // MATCH_LT
    endcase
  end

  assign match_if_o = is_mc6 && cfg_i.tdata1[MC6_EXECUTE] && if_addr_hit && !debug_mode_i &&
                      priv_enabled(priv_if_i, cfg_i.tdata1[MC6_M], cfg_i.tdata1[MC6_U]);

  ////////////////////////////////////////
  // Load / store address
  ////////////////////////////////////////

  // Edges of the accessed byte range
  always_comb begin
    be_hi_lsb = 2'd0;
    be_lo_lsb = 2'd3;
    for (int b = 0; b < 4; b++) begin
      if (lsu_ex_i.be[b]) be_hi_lsb = 2'(b);       // Last set bit wins
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_ex_i.be[b]) be_lo_lsb = 2'(b);       // First set bit wins
    end
  end

  assign lsu_addr_hi = {lsu_ex_i.addr[XLEN-1:2], be_hi_lsb};
  assign lsu_addr_lo = {lsu_ex_i.addr[XLEN-1:2], be_lo_lsb};
  assign byte_sel    = 4'b0001 << tdata2[1:0];

  always_comb begin
    case (match_rule)
      // Same word, and the addressed byte is part of the access
      MATCH_EQ: lsu_addr_hit = (lsu_ex_i.addr[XLEN-1:2] == tdata2[XLEN-1:2]) &&
                               |(lsu_ex_i.be & byte_sel);
      MATCH_GE: lsu_addr_hit = lsu_addr_hi >= tdata2;
      default:  lsu_addr_hit = lsu_addr_lo <  tdata2;
    endcase
  end

  assign lsu_dir_en = (cfg_i.tdata1[MC6_LOAD]  && !lsu_ex_i.we) ||
                      (cfg_i.tdata1[MC6_STORE] &&  lsu_ex_i.we);

  assign match_ex_o = is_mc6 && lsu_ex_i.valid && lsu_dir_en && lsu_addr_hit && !debug_mode_i &&
                      priv_enabled(lsu_ex_i.priv, cfg_i.tdata1[MC6_M], cfg_i.tdata1[MC6_U]);

  ////////////////////////////////////////
  // Exception cause
  ////////////////////////////////////////

  // Causes beyond bit 31 of tdata2 never hit
  assign exc_code_hit = (exc_wb_i.cause < 11'(XLEN)) && tdata2[exc_wb_i.cause[4:0]];

  assign etrigger_o = is_etrig && exc_wb_i.valid && exc_code_hit && !debug_mode_i &&
                      priv_enabled(exc_wb_i.priv, cfg_i.tdata1[ETRIG_M], cfg_i.tdata1[ETRIG_U]);

endmodule

// File: verilog/trigger_csrs.sv
`timescale 1ns/1ps

module trigger_csrs (
  input  logic                            clk,
  input  logic                            reset_i,
  input  dbg_trig_pkg::csr_wr_t           csr_wr_i,
  input  logic [dbg_trig_pkg::XLEN-1:0]   tselect_n_i,   // Resolved next tselect
  input  logic [dbg_trig_pkg::XLEN-1:0]   tdata1_n_i,    // Resolved next tdata1
  input  logic [dbg_trig_pkg::XLEN-1:0]   tdata2_n_i,    // Resolved next tdata2
  output dbg_trig_pkg::trig_cfg_t         cfg_o [dbg_trig_pkg::NUM_TRIGGERS],
  output dbg_trig_pkg::csr_rd_t           csr_rd_o
);
  import dbg_trig_pkg::*;

  logic [TSEL_W-1:0]       tselect_q;
  logic [XLEN-1:0]         tdata1_q [NUM_TRIGGERS];
  logic [XLEN-1:0]         tdata2_q [NUM_TRIGGERS];
  logic [NUM_TRIGGERS-1:0] tdata1_we;                // Decoded per-trigger strobes
  logic [NUM_TRIGGERS-1:0] tdata2_we;

  ////////////////////////////////////////
  // tselect
  ////////////////////////////////////////

  // Next value is already in range, upper bits are zero
  always_ff @(posedge clk) begin
    if (reset_i) begin
      tselect_q <= '0;
    end else if (csr_wr_i.tselect_we) begin
      tselect_q <= tselect_n_i[TSEL_W-1:0];
    end
  end

  ////////////////////////////////////////
  // Per-trigger tdata1 / tdata2
  ////////////////////////////////////////

  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : g_regs
    // Decode against the current selection, a same-cycle tselect write
    // lands afterwards
    assign tdata1_we[t] = csr_wr_i.tdata1_we && (tselect_q == TSEL_W'(t));
    assign tdata2_we[t] = csr_wr_i.tdata2_we && (tselect_q == TSEL_W'(t));

    always_ff @(posedge clk) begin
      if (reset_i) begin
        tdata1_q[t] <= TDATA1_RST_VAL;   // Disabled after reset
        tdata2_q[t] <= '0;
      end else begin
        if (tdata1_we[t]) begin
          tdata1_q[t] <= tdata1_n_i;
        end
        if (tdata2_we[t]) begin
          tdata2_q[t] <= tdata2_n_i;
        end
      end
    end

    assign cfg_o[t].tdata1 = tdata1_q[t];
    assign cfg_o[t].tdata2 = tdata2_q[t];
  end

  ////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////

  // Zero-latency mux of the selected trigger
  always_comb begin
    csr_rd_o.tselect  = XLEN'(tselect_q);
    csr_rd_o.tdata1   = tdata1_q[tselect_q];
    csr_rd_o.tdata2   = tdata2_q[tselect_q];
    csr_rd_o.tdata3   = '0;          // Not implemented
    csr_rd_o.tinfo    = TINFO_VAL;
    csr_rd_o.tcontrol = '0;          // Not implemented
  end

endmodule

// File: verilog/trigger_warl.sv
`timescale 1ns/1ps

module trigger_warl (
  input  logic [dbg_trig_pkg::XLEN-1:0] wdata_i,       // Raw CSR write data
  input  logic [dbg_trig_pkg::XLEN-1:0] cur_tselect_i,
  input  logic [dbg_trig_pkg::XLEN-1:0] cur_tdata1_i,  // Selected trigger tdata1
  input  logic [dbg_trig_pkg::XLEN-1:0] cur_tdata2_i,  // Selected trigger tdata2
  output logic [dbg_trig_pkg::XLEN-1:0] tselect_n_o,
  output logic [dbg_trig_pkg::XLEN-1:0] tdata1_n_o,
  output logic [dbg_trig_pkg::XLEN-1:0] tdata2_n_o
);
  import dbg_trig_pkg::*;

  logic [3:0] wr_type;     // Type field of the write data
  logic [3:0] cur_type;    // Type field currently stored
  logic       tdata2_bad;  // tdata2 holds an exception code we never raise

  // Only EQ, GE and LT are implemented, anything else falls back to EQ
  function automatic logic [3:0] match_resolve(input logic [3:0] req);
    logic [3:0] res;
    case (req)
      MATCH_EQ, MATCH_GE, MATCH_LT: res = req;
      default:                      res = MATCH_EQ;
    endcase
    return res;
  endfunction

  assign wr_type    = wdata_i[TTYPE_HI:TTYPE_LO];
  assign cur_type   = cur_tdata1_i[TTYPE_HI:TTYPE_LO];
  assign tdata2_bad = |(cur_tdata2_i & ~ETRIG_TDATA2_MASK);

  ////////////////////////////////////////
  // tselect
  ////////////////////////////////////////

  // Out of range index keeps the old selection
  assign tselect_n_o = (wdata_i < XLEN'(NUM_TRIGGERS)) ? wdata_i : cur_tselect_i;

  ////////////////////////////////////////
  // tdata1
  ////////////////////////////////////////

  always_comb begin
    tdata1_n_o = TDATA1_RST_VAL;                          // Default is a disabled trigger
    case (wr_type)
      TT_MCONTROL6: begin
        tdata1_n_o                             = '0;
        tdata1_n_o[TTYPE_HI:TTYPE_LO]          = TT_MCONTROL6;
        tdata1_n_o[DMODE_BIT]                  = 1'b1;   // Writable from debug mode only
        tdata1_n_o[15:12]                      = 4'h1;   // Action, enter debug mode
        tdata1_n_o[MC6_MATCH_HI:MC6_MATCH_LO]  =
          match_resolve(wdata_i[MC6_MATCH_HI:MC6_MATCH_LO]);
        tdata1_n_o[MC6_M]                      = wdata_i[MC6_M];
        tdata1_n_o[MC6_U]                      = wdata_i[MC6_U];
        tdata1_n_o[MC6_EXECUTE]                = wdata_i[MC6_EXECUTE];
        tdata1_n_o[MC6_STORE]                  = wdata_i[MC6_STORE];
        tdata1_n_o[MC6_LOAD]                   = wdata_i[MC6_LOAD];
      end
      TT_ETRIGGER: begin
        // Accept only when tdata2 already holds legal codes
        if (!tdata2_bad) begin
          tdata1_n_o                    = '0;
          tdata1_n_o[TTYPE_HI:TTYPE_LO] = TT_ETRIGGER;
          tdata1_n_o[DMODE_BIT]         = 1'b1;
          tdata1_n_o[5:0]               = 6'd1;          // Action, enter debug mode
          tdata1_n_o[ETRIG_M]           = wdata_i[ETRIG_M];
          tdata1_n_o[ETRIG_U]           = wdata_i[ETRIG_U];
        end
      end
      default: begin
        // Disabled, legacy mcontrol and unknown types
        tdata1_n_o = TDATA1_RST_VAL;
      end
    endcase
  end

  ////////////////////////////////////////
  // tdata2
  ////////////////////////////////////////

  // Exception trigger keeps only the implemented cause bits
  always_comb begin
    if (cur_type == TT_ETRIGGER) begin
      tdata2_n_o = wdata_i & ETRIG_TDATA2_MASK;
    end else begin
      tdata2_n_o = wdata_i;                               // Any address is legal
    end
  end

endmodule

// File: verilog/dbg_trig_pkg.sv
package dbg_trig_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int NUM_TRIGGERS = 2;   // Implemented trigger count
  localparam int XLEN         = 32;  // CSR and address width
  localparam int TSEL_W       = 1;   // Width of a trigger index

  ////////////////////////////////////////
  // tdata1 field positions
  ////////////////////////////////////////

  localparam int TTYPE_HI  = 31;
  localparam int TTYPE_LO  = 28;
  localparam int DMODE_BIT = 27;     // Debug-mode-only access

  // mcontrol6 layout
  localparam int MC6_MATCH_HI = 10;
  localparam int MC6_MATCH_LO = 7;
  localparam int MC6_M        = 6;   // Match in machine mode
  localparam int MC6_U        = 3;   // Match in user mode
  localparam int MC6_EXECUTE  = 2;
  localparam int MC6_STORE    = 1;
  localparam int MC6_LOAD     = 0;

  // Exception trigger layout
  localparam int ETRIG_M = 9;
  localparam int ETRIG_U = 6;

  // Exception codes the core can raise: 0,1,2,3,5,7,8,11
  localparam logic [XLEN-1:0] ETRIG_TDATA2_MASK = 32'h0000_09AF;

  // Disabled type with dmode set
  localparam logic [XLEN-1:0] TDATA1_RST_VAL = 32'hF800_0000;

  // Types 5, 6 and 15 supported
  localparam logic [XLEN-1:0] TINFO_VAL = 32'h0000_8060;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    TT_ETRIGGER  = 4'd5,
    TT_MCONTROL6 = 4'd6,
    TT_DISABLED  = 4'd15
  } ttype_e;

  typedef enum logic [3:0] {
    MATCH_EQ = 4'd0,  // Address equal
    MATCH_GE = 4'd2,  // Address greater or equal
    MATCH_LT = 4'd3   // Address less than
  } match_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_lvl_e;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // CSR unit write port, strobes qualify wdata
  typedef struct packed {
    logic [XLEN-1:0] wdata;
    logic            tselect_we;
    logic            tdata1_we;
    logic            tdata2_we;
  } csr_wr_t;

  // Read data for every trigger CSR
  typedef struct packed {
    logic [XLEN-1:0] tselect;
    logic [XLEN-1:0] tdata1;
    logic [XLEN-1:0] tdata2;
    logic [XLEN-1:0] tdata3;
    logic [XLEN-1:0] tinfo;
    logic [XLEN-1:0] tcontrol;
  } csr_rd_t;

  // EX stage LSU request
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
    logic            we;    // High for stores
    logic [3:0]      be;    // Byte enables within the word
    priv_lvl_e       priv;
  } lsu_req_t;

  // WB stage exception
  typedef struct packed {
    logic        valid;
    logic [10:0] cause;
    priv_lvl_e   priv;
  } exc_wb_t;

  // Stored configuration of one trigger
  typedef struct packed {
    logic [XLEN-1:0] tdata1;
    logic [XLEN-1:0] tdata2;
  } trig_cfg_t;

endpackage
